// ==== all.f ====
+incdir+.
mipsPkg.sv
instrDecoder.sv
regFile.sv
pipeAlu.sv
hazardForward.sv
fetchStage.sv
dataMem.sv
mipsPipeline.sv
tbMipsPipeline.sv

// ==== tbModel.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int progLen = 36;
localparam int imemWords = 64;

mipsPkg::wordT prog [imemWords];
mipsPkg::regIdxT expWReg [$];
mipsPkg::wordT expWData [$];
mipsPkg::wordT expSAddr [$];
mipsPkg::wordT expSData [$];

function automatic mipsPkg::wordT rEnc(mipsPkg::functT fn, int rs, int rt, int rd);
	return {mipsPkg::opRtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
endfunction

function automatic mipsPkg::wordT iEnc(mipsPkg::opcodeT op, int rs, int rt, logic [15:0] imm);
	return {op, 5'(rs), 5'(rt), imm};
endfunction

function automatic mipsPkg::wordT jEnc(int idx);
	return {mipsPkg::opJ, 26'(idx)};
endfunction

// Scratch registers, r1 and r2 stay fixed for the branches
function automatic int pickReg();
	return 3 + ($urandom % 13);
endfunction

task automatic buildProgram();
	int ra;
	int rb;
	int rc;
	int off;
	ra = pickReg();
	rb = pickReg();
	rc = pickReg();
	off = 4 * ($urandom % 32);
	for (int i = 0; i < imemWords; i++)
		prog[i] = '0;
	prog[0] = iEnc(mipsPkg::opAddi, 0, 1, 16'($urandom));
	prog[1] = iEnc(mipsPkg::opAddiu, 1, 2, 16'(1 + $urandom % 1000)); // r2 differs from r1
	prog[2] = rEnc(mipsPkg::fnAdd, 1, 2, 3);
	prog[3] = rEnc(mipsPkg::fnSub, 3, 1, 4);
	prog[4] = iEnc(mipsPkg::opLui, 0, ra, 16'($urandom));
	prog[5] = iEnc(mipsPkg::opOri, ra, ra, 16'($urandom));
	prog[6] = rEnc(mipsPkg::fnAnd, ra, 3, rb);
	prog[7] = rEnc(mipsPkg::fnOr, rb, 4, rc);
	prog[8] = rEnc(mipsPkg::fnXor, rc, ra, 5);
	prog[9] = rEnc(mipsPkg::fnNor, 5, 1, 6);
	prog[10] = rEnc(mipsPkg::fnSlt, 6, 1, 7);
	prog[11] = rEnc(mipsPkg::fnSltu, 6, 1, 8);
	prog[12] = iEnc(mipsPkg::opSlti, 4, 9, 16'($urandom));
	prog[13] = iEnc(mipsPkg::opAndi, ra, 10, 16'($urandom));
	prog[14] = iEnc(mipsPkg::opXori, ra, 11, 16'($urandom));
	prog[15] = iEnc(mipsPkg::opAddi, 1, 0, 16'd5); // r0 targets
	prog[16] = rEnc(mipsPkg::fnAdd, 1, 2, 0);
	prog[17] = rEnc(mipsPkg::fnAdd, 0, 1, 15);
	prog[18] = iEnc(mipsPkg::opSw, 0, 3, 16'(off));
	prog[19] = iEnc(mipsPkg::opLw, 0, 16, 16'(off));
	prog[20] = rEnc(mipsPkg::fnAdd, 16, 1, 17); // Load-use
	prog[21] = iEnc(mipsPkg::opSw, 0, 17, 16'(off + 4));
	prog[22] = iEnc(mipsPkg::opBeq, 1, 1, 16'd2);
	prog[23] = iEnc(mipsPkg::opAddi, 0, 18, 16'd1);
	prog[24] = iEnc(mipsPkg::opAddi, 0, 19, 16'd2);
	prog[25] = iEnc(mipsPkg::opBne, 1, 1, 16'd1);
	prog[26] = iEnc(mipsPkg::opAddi, 0, 20, 16'($urandom));
	prog[27] = iEnc(mipsPkg::opBne, 1, 2, 16'd1);
	prog[28] = iEnc(mipsPkg::opAddi, 0, 21, 16'd3);
	prog[29] = iEnc(mipsPkg::opBeq, 1, 2, 16'd1);
	prog[30] = jEnc(33);
	prog[31] = iEnc(mipsPkg::opAddi, 0, 22, 16'd4);
	prog[32] = iEnc(mipsPkg::opAddi, 0, 23, 16'd5);
	prog[33] = rEnc(mipsPkg::fnAddu, 20, 17, 24);
	prog[34] = rEnc(mipsPkg::fnSubu, 24, 3, 25);
	prog[35] = jEnc(35); // Self-loop
endtask

`endif

// ==== tbMipsPipeline.sv ====
`timescale 1ns/1ns

module tbMipsPipeline;

	`include "tbModel.svh"

	localparam int timeoutCycles = 10 * progLen + 20;

	logic Clk;
	logic rstN;
	mipsPkg::wordT imemAddr;
	mipsPkg::wordT imemData;
	logic wbEn;
	mipsPkg::regIdxT wbReg;
	mipsPkg::wordT wbData;
	logic memWe;
	mipsPkg::wordT memAddr;
	mipsPkg::wordT memWdata;

	int errors = 0;
	int checks = 0;
	int wIdx = 0;
	int sIdx = 0;
	int cycle = 0;

	mipsPipeline #(.dmemWords(256)) uut (.Clk(Clk), .rstN(rstN), .imemAddr(imemAddr),
		.imemData(imemData), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .memWe(memWe),
		.memAddr(memAddr), .memWdata(memWdata));

	assign imemData = (imemAddr[31:2] < imemWords) ? prog[imemAddr[31:2]] : '0;

	// Sequential ISA reference, stops at the self-loop
	task automatic runModel();
		mipsPkg::wordT r [32];
		mipsPkg::wordT dm [mipsPkg::wordT];
		mipsPkg::wordT pc;
		mipsPkg::wordT ins;
		mipsPkg::wordT a;
		mipsPkg::wordT b;
		mipsPkg::wordT simm;
		mipsPkg::wordT zimm;
		mipsPkg::wordT nextPc;
		mipsPkg::wordT val;
		int dest;
		pc = 0;
		for (int i = 0; i < 32; i++)
			r[i] = '0;
		for (int step = 0; step < 200; step++) begin
			ins = prog[pc[31:2]];
			a = r[ins[25:21]];
			b = r[ins[20:16]];
			simm = {{16{ins[15]}}, ins[15:0]};
			zimm = {16'b0, ins[15:0]};
			nextPc = pc + 4;
			dest = 0;
			case (ins[31:26])
				mipsPkg::opRtype: begin
					dest = ins[15:11];
					case (ins[5:0])
						mipsPkg::fnAdd, mipsPkg::fnAddu: val = a + b;
						mipsPkg::fnSub, mipsPkg::fnSubu: val = a - b;
						mipsPkg::fnAnd: val = a & b;
						mipsPkg::fnOr: val = a | b;
						mipsPkg::fnXor: val = a ^ b;
						mipsPkg::fnNor: val = ~(a | b);
						mipsPkg::fnSlt: val = ($signed(a) < $signed(b)) ? 1 : 0;
						default: val = (a < b) ? 1 : 0;
					endcase
				end
				mipsPkg::opAddi, mipsPkg::opAddiu: begin
					dest = ins[20:16];
					val = a + simm;
				end
				mipsPkg::opSlti: begin
					dest = ins[20:16];
					val = ($signed(a) < $signed(simm)) ? 1 : 0;
				end
				mipsPkg::opSltiu: begin
					dest = ins[20:16];
					val = (a < simm) ? 1 : 0;
				end
				mipsPkg::opAndi: begin
					dest = ins[20:16];
					val = a & zimm;
				end
				mipsPkg::opOri: begin
					dest = ins[20:16];
					val = a | zimm;
				end
				mipsPkg::opXori: begin
					dest = ins[20:16];
					val = a ^ zimm;
				end
				mipsPkg::opLui: begin
					dest = ins[20:16];
					val = {ins[15:0], 16'b0};
				end
				mipsPkg::opLw: begin
					dest = ins[20:16];
					val = dm[a + simm];
				end
				mipsPkg::opSw: begin
					dm[a + simm] = b;
					expSAddr.push_back(a + simm);
					expSData.push_back(b);
				end
				mipsPkg::opBeq: if (a == b) nextPc = pc + 4 + (simm << 2);
				mipsPkg::opBne: if (a != b) nextPc = pc + 4 + (simm << 2);
				mipsPkg::opJ: begin
					nextPc = {nextPc[31:28], ins[25:0], 2'b00};
					if (nextPc == pc)
						return;
				end
				default: ;
			endcase
			if (dest != 0) begin
				r[dest] = val;
				expWReg.push_back(5'(dest));
				expWData.push_back(val);
			end
			pc = nextPc;
		end
	endtask

	task automatic reportCounts();
		$display("Checks %0d, errors %0d, writes %0d of %0d, stores %0d of %0d",
			checks, errors, wIdx, expWReg.size(), sIdx, expSAddr.size());
	endtask

	initial begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	always @(posedge Clk)
		if (rstN)
			cycle <= cycle + 1;

	// Outputs are settled at the falling edge
	always @(negedge Clk) begin
		if (rstN && cycle < 4) begin
			checks++;
			assert (wbEn === 1'b0 && memWe === 1'b0) else begin
				errors++;
				$display("CHECK FAILED t=%0t wbEn/memWe expected 0/0 got %b/%b",
					$time, wbEn, memWe);
			end
		end
		if (rstN && wbEn === 1'b1) begin
			checks++;
			assert (wbReg != 0) else begin
				errors++;
				$display("Retire to register 0 at t=%0t", $time);
			end
			if (wIdx >= expWReg.size()) begin
				errors++;
				$display("Extra retire to r%0d at t=%0t", wbReg, $time);
			end else begin
				assert (wbReg === expWReg[wIdx]) else begin
					errors++;
					$display("CHECK FAILED t=%0t wbReg expected %0d got %0d",
						$time, expWReg[wIdx], wbReg);
				end
				assert (wbData === expWData[wIdx]) else begin
					errors++;
					$display("CHECK FAILED t=%0t wbData expected %h got %h",
						$time, expWData[wIdx], wbData);
				end
				wIdx++;
			end
		end
		if (rstN && memWe === 1'b1) begin
			checks++;
			if (sIdx >= expSAddr.size()) begin
				errors++;
				$display("Extra store to %h at t=%0t", memAddr, $time);
			end else begin
				assert (memAddr === expSAddr[sIdx]) else begin
					errors++;
					$display("CHECK FAILED t=%0t memAddr expected %h got %h",
						$time, expSAddr[sIdx], memAddr);
				end
				assert (memWdata === expSData[sIdx]) else begin
					errors++;
					$display("CHECK FAILED t=%0t memWdata expected %h got %h",
						$time, expSData[sIdx], memWdata);
				end
				sIdx++;
			end
		end
	end

	initial begin
		#(timeoutCycles * 8);
		errors++;
		$display("Timeout after %0d cycles, retires still missing", timeoutCycles);
		reportCounts();
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		rstN = 1'b0;
		void'($urandom(32'h1115b517));
		buildProgram();
		runModel();
		repeat (2) @(posedge Clk);
		rstN <= 1'b1;
		wait (wIdx == expWReg.size() && sIdx == expSAddr.size());
		repeat (10) @(posedge Clk); // Self-loop must stay silent
		reportCounts();
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== mipsPipeline.sv ====
`timescale 1ns/1ns

module mipsPipeline #(
	parameter int dmemWords = 256
) (
	input  logic            Clk,
	input  logic            rstN,
	output mipsPkg::wordT   imemAddr,
	input  mipsPkg::wordT   imemData,
	output logic            wbEn,
	output mipsPkg::regIdxT wbReg,
	output mipsPkg::wordT   wbData,
	output logic            memWe,
	output mipsPkg::wordT   memAddr,
	output mipsPkg::wordT   memWdata
);

	// Decode
	mipsPkg::wordT idInstr, idPcPlus4, idImm, idJumpTarget, idRsData, idRtData;
	logic idRegWrite, idMemRead, idMemWrite, idAluSrcImm, idSignExt;
	logic idBeq, idBne, idJump, idRegDstRd;
	mipsPkg::aluOpT idAluOp;
	mipsPkg::regIdxT idDest, idRtSrc;

	// Execute
	logic exRegWrite, exMemRead, exMemWrite, exAluSrcImm, exBeq, exBne;
	mipsPkg::aluOpT exAluOp;
	mipsPkg::regIdxT exDest, exRs, exRt;
	mipsPkg::wordT exRsData, exRtData, exImm, exPcPlus4;
	mipsPkg::wordT opA, opB, aluB, aluResult, branchTarget;
	logic aluZero, branchTaken;

	// Memory
	logic memRegWrite, memMemRead, memMemWrite;
	mipsPkg::regIdxT memDest;
	mipsPkg::wordT memAluResult, memStoreData, dmemRdata;

	// Control
	mipsPkg::fwdSelT fwdA, fwdB;
	logic stall, flushIfId, flushIdEx, redirect;
	mipsPkg::wordT redirectTarget;

	function automatic mipsPkg::wordT fwdMux(input mipsPkg::fwdSelT sel,
			input mipsPkg::wordT regVal, input mipsPkg::wordT memVal,
			input mipsPkg::wordT wbVal);
		case (sel)
			mipsPkg::fwdMem: return memVal;
			mipsPkg::fwdWb:  return wbVal;
			default:         return regVal;
		endcase
	endfunction

	fetchStage fetch (.Clk(Clk), .rstN(rstN), .stall(stall), .flushIfId(flushIfId),
		.redirect(redirect), .target(redirectTarget), .imemData(imemData),
		.pc(imemAddr), .idInstr(idInstr), .idPcPlus4(idPcPlus4));

	instrDecoder decoder (.instr(idInstr), .regWrite(idRegWrite), .memRead(idMemRead),
		.memWrite(idMemWrite), .aluSrcImm(idAluSrcImm), .signExt(idSignExt),
		.isBranchEq(idBeq), .isBranchNe(idBne), .isJump(idJump), .regDstRd(idRegDstRd),
		.aluOp(idAluOp), .destReg(idDest));

	regFile regs (.Clk(Clk), .rstN(rstN), .rs(idInstr[25:21]), .rt(idInstr[20:16]),
		.we(wbEn), .wAddr(wbReg), .wData(wbData), .rsData(idRsData), .rtData(idRtData));

	// rt is only a source for register-type, store and branch
	assign idRtSrc = (idRegDstRd || idMemWrite || idBeq || idBne) ? idInstr[20:16] : '0;

	hazardForward hazard (.idRs(idInstr[25:21]), .idRt(idRtSrc), .exRs(exRs), .exRt(exRt),
		.exDest(exDest), .memDest(memDest), .wbDest(wbReg), .exMemRead(exMemRead),
		.memRegWrite(memRegWrite), .wbRegWrite(wbEn), .branchTaken(branchTaken),
		.jumpId(idJump), .fwdA(fwdA), .fwdB(fwdB), .stall(stall),
		.flushIfId(flushIfId), .flushIdEx(flushIdEx));

	assign idImm = idSignExt ? {{16{idInstr[15]}}, idInstr[15:0]} : {16'b0, idInstr[15:0]};
	assign idJumpTarget = {idPcPlus4[31:28], idInstr[25:0], 2'b00};

	always_ff @(posedge Clk) begin
		if (!rstN || flushIdEx) begin
			exRegWrite <= 1'b0;
			exMemRead <= 1'b0;
			exMemWrite <= 1'b0;
			exBeq <= 1'b0;
			exBne <= 1'b0;
		end else begin
			exRegWrite <= idRegWrite;
			exMemRead <= idMemRead;
			exMemWrite <= idMemWrite;
			exBeq <= idBeq;
			exBne <= idBne;
		end
	end

	always_ff @(posedge Clk) begin
		exAluSrcImm <= idAluSrcImm;
		exAluOp <= idAluOp;
		exDest <= idDest;
		exRs <= idInstr[25:21];
		exRt <= idInstr[20:16];
		exRsData <= idRsData;
		exRtData <= idRtData;
		exImm <= idImm;
		exPcPlus4 <= idPcPlus4;
	end

	assign opA = fwdMux(fwdA, exRsData, memAluResult, wbData);
	assign opB = fwdMux(fwdB, exRtData, memAluResult, wbData);
	assign aluB = exAluSrcImm ? exImm : opB;

	pipeAlu alu (.op(exAluOp), .a(opA), .b(aluB), .result(aluResult), .zero(aluZero));

	assign branchTaken = (exBeq && aluZero) || (exBne && !aluZero);
	assign branchTarget = exPcPlus4 + {exImm[29:0], 2'b00};

	// Older branch wins over a jump in decode
	assign redirect = branchTaken || idJump;
	assign redirectTarget = branchTaken ? branchTarget : idJumpTarget;

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			memRegWrite <= 1'b0;
			memMemRead <= 1'b0;
			memMemWrite <= 1'b0;
		end else begin
			memRegWrite <= exRegWrite;
			memMemRead <= exMemRead;
			memMemWrite <= exMemWrite;
		end
	end

	always_ff @(posedge Clk) begin
		memDest <= exDest;
		memAluResult <= aluResult;
		memStoreData <= opB; // Forwarded rt
	end

	dataMem #(.dmemWords(dmemWords)) dmem (.Clk(Clk), .we(memMemWrite),
		.addr(memAluResult), .wData(memStoreData), .rData(dmemRdata));

	assign memWe = memMemWrite;
	assign memAddr = memAluResult;
	assign memWdata = memStoreData;

	always_ff @(posedge Clk) begin
		if (!rstN)
			wbEn <= 1'b0;
		else
			wbEn <= memRegWrite;
	end

	always_ff @(posedge Clk) begin
		wbReg <= memDest;
		wbData <= memMemRead ? dmemRdata : memAluResult;
	end

endmodule

// ==== dataMem.sv ====
`timescale 1ns/1ns

module dataMem #(
	parameter int dmemWords = 256
) (
	input  logic          Clk,
	input  logic          we,
	input  mipsPkg::wordT addr,
	input  mipsPkg::wordT wData,
	output mipsPkg::wordT rData
);

	localparam int idxW = $clog2(dmemWords);

	mipsPkg::wordT mem [dmemWords];
	logic [idxW-1:0] wordIdx;

	assign wordIdx = idxW'(addr[31:2] % dmemWords); // Byte offset ignored

	always_ff @(posedge Clk) begin
		if (we)
			mem[wordIdx] <= wData;
	end

	assign rData = mem[wordIdx];

endmodule

// ==== fetchStage.sv ====
`timescale 1ns/1ns

module fetchStage (
	input  logic          Clk,
	input  logic          rstN,
	input  logic          stall,
	input  logic          flushIfId,
	input  logic          redirect,
	input  mipsPkg::wordT target,
	input  mipsPkg::wordT imemData,
	output mipsPkg::wordT pc,
	output mipsPkg::wordT idInstr,
	output mipsPkg::wordT idPcPlus4
);

	mipsPkg::wordT pcPlus4;

	assign pcPlus4 = pc + 32'd4;

	always_ff @(posedge Clk) begin
		if (!rstN)
			pc <= mipsPkg::resetPc;
		else if (redirect)
			pc <= target; // Over a load-use hold too
		else if (!stall)
			pc <= pcPlus4;
	end

	always_ff @(posedge Clk) begin
		if (!rstN)
			idInstr <= '0;
		else if (flushIfId)
			idInstr <= '0; // All-zero word decodes as a bubble
		else if (!stall)
			idInstr <= imemData;
	end

	always_ff @(posedge Clk) begin
		if (!stall)
			idPcPlus4 <= pcPlus4;
	end

endmodule

// ==== hazardForward.sv ====
`timescale 1ns/1ns

module hazardForward (
	input  mipsPkg::regIdxT idRs,
	input  mipsPkg::regIdxT idRt,
	input  mipsPkg::regIdxT exRs,
	input  mipsPkg::regIdxT exRt,
	input  mipsPkg::regIdxT exDest,
	input  mipsPkg::regIdxT memDest,
	input  mipsPkg::regIdxT wbDest,
	input  logic            exMemRead,
	input  logic            memRegWrite,
	input  logic            wbRegWrite,
	input  logic            branchTaken,
	input  logic            jumpId,
	output mipsPkg::fwdSelT fwdA,
	output mipsPkg::fwdSelT fwdB,
	output logic            stall,
	output logic            flushIfId,
	output logic            flushIdEx
);

	logic loadUse;

	// Youngest producer wins
	function automatic mipsPkg::fwdSelT pickSrc(input mipsPkg::regIdxT src);
		if (memRegWrite && memDest != '0 && memDest == src)
			return mipsPkg::fwdMem;
		else if (wbRegWrite && wbDest != '0 && wbDest == src)
			return mipsPkg::fwdWb;
		return mipsPkg::fwdNone;
	endfunction

	always_comb begin
		fwdA = pickSrc(exRs);
		fwdB = pickSrc(exRt);
	end

	assign loadUse = exMemRead && exDest != '0 && (exDest == idRs || exDest == idRt);

	assign stall = loadUse;
	assign flushIdEx = loadUse || branchTaken; // Bubble into execute
	assign flushIfId = branchTaken || jumpId;

	// Load and branch cannot share the execute stage
	noStallOnBranch: assert final ($isunknown({stall, branchTaken}) || !(stall && branchTaken));

endmodule

// ==== pipeAlu.sv ====
`timescale 1ns/1ns

module pipeAlu (
	input  mipsPkg::aluOpT op,
	input  mipsPkg::wordT  a,
	input  mipsPkg::wordT  b,
	output mipsPkg::wordT  result,
	output logic           zero
);

	mipsPkg::wordT diff;

	assign diff = a - b;
	assign zero = (diff == '0); // Equal operands, used by branches

	always_comb begin
		case (op)
			mipsPkg::aluAnd:  result = a & b;
			mipsPkg::aluOr:   result = a | b;
			mipsPkg::aluAdd:  result = a + b; // No overflow trap
			mipsPkg::aluXor:  result = a ^ b;
			mipsPkg::aluNor:  result = ~(a | b);
			mipsPkg::aluSub:  result = diff;
			mipsPkg::aluSlt:  result = {31'b0, $signed(a) < $signed(b)};
			mipsPkg::aluSltu: result = {31'b0, a < b};
			mipsPkg::aluLui:  result = {b[15:0], 16'b0};
			default:          result = '0;
		endcase
	end

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ns

module regFile (
	input  logic            Clk,
	input  logic            rstN,
	input  mipsPkg::regIdxT rs,
	input  mipsPkg::regIdxT rt,
	input  logic            we,
	input  mipsPkg::regIdxT wAddr,
	input  mipsPkg::wordT   wData,
	output mipsPkg::wordT   rsData,
	output mipsPkg::wordT   rtData
);

	mipsPkg::wordT regs [32];

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wAddr != '0) begin
			regs[wAddr] <= wData;
		end
	end

	// r0 reads zero, same-cycle write passes through
	assign rsData = (rs == '0) ? '0 : (we && wAddr == rs) ? wData : regs[rs];
	assign rtData = (rt == '0) ? '0 : (we && wAddr == rt) ? wData : regs[rt];

	// Decoder drops r0 writes long before write-back
	noZeroWrite: assert property (@(posedge Clk) disable iff (!rstN) !(we && wAddr == '0));

endmodule

// ==== instrDecoder.sv ====
`timescale 1ns/1ns

module instrDecoder (
	input  mipsPkg::wordT   instr,
	output logic            regWrite,
	output logic            memRead,
	output logic            memWrite,
	output logic            aluSrcImm,
	output logic            signExt,
	output logic            isBranchEq,
	output logic            isBranchNe,
	output logic            isJump,
	output logic            regDstRd,
	output mipsPkg::aluOpT  aluOp,
	output mipsPkg::regIdxT destReg
);

	mipsPkg::opcodeT opcode;
	mipsPkg::functT funct;
	logic known;
	logic writesReg; // Before the unknown and r0 checks

	assign opcode = instr[31:26];
	assign funct = instr[5:0];

	always_comb begin
		known = 1'b1;
		writesReg = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		aluSrcImm = 1'b0;
		signExt = 1'b0;
		isBranchEq = 1'b0;
		isBranchNe = 1'b0;
		isJump = 1'b0;
		regDstRd = 1'b0;
		aluOp = mipsPkg::aluAdd;
		case (opcode)
			mipsPkg::opRtype: begin
				regDstRd = 1'b1;
				writesReg = 1'b1;
				case (funct)
					mipsPkg::fnAdd, mipsPkg::fnAddu: aluOp = mipsPkg::aluAdd;
					mipsPkg::fnSub, mipsPkg::fnSubu: aluOp = mipsPkg::aluSub;
					mipsPkg::fnAnd:  aluOp = mipsPkg::aluAnd;
					mipsPkg::fnOr:   aluOp = mipsPkg::aluOr;
					mipsPkg::fnXor:  aluOp = mipsPkg::aluXor;
					mipsPkg::fnNor:  aluOp = mipsPkg::aluNor;
					mipsPkg::fnSlt:  aluOp = mipsPkg::aluSlt;
					mipsPkg::fnSltu: aluOp = mipsPkg::aluSltu;
					default: known = 1'b0; // Includes the all-zero bubble
				endcase
			end
			mipsPkg::opAddi, mipsPkg::opAddiu, mipsPkg::opSlti, mipsPkg::opSltiu: begin
				writesReg = 1'b1;
				aluSrcImm = 1'b1;
				signExt = 1'b1;
				if (opcode == mipsPkg::opSlti)
					aluOp = mipsPkg::aluSlt;
				else if (opcode == mipsPkg::opSltiu)
					aluOp = mipsPkg::aluSltu; // Sign extended, compared unsigned
			end
			mipsPkg::opAndi, mipsPkg::opOri, mipsPkg::opXori, mipsPkg::opLui: begin
				writesReg = 1'b1;
				aluSrcImm = 1'b1;
				case (opcode)
					mipsPkg::opAndi: aluOp = mipsPkg::aluAnd;
					mipsPkg::opOri:  aluOp = mipsPkg::aluOr;
					mipsPkg::opXori: aluOp = mipsPkg::aluXor;
					default:         aluOp = mipsPkg::aluLui;
				endcase
			end
			mipsPkg::opLw: begin
				writesReg = 1'b1;
				memRead = 1'b1;
				aluSrcImm = 1'b1;
				signExt = 1'b1;
			end
			mipsPkg::opSw: begin
				memWrite = 1'b1;
				aluSrcImm = 1'b1;
				signExt = 1'b1;
			end
			mipsPkg::opBeq, mipsPkg::opBne: begin
				aluOp = mipsPkg::aluSub; // Zero flag decides
				signExt = 1'b1;          // Offset for the target adder
				isBranchEq = (opcode == mipsPkg::opBeq);
				isBranchNe = (opcode == mipsPkg::opBne);
			end
			mipsPkg::opJ: isJump = 1'b1;
			default: known = 1'b0;
		endcase
	end

	assign destReg = regDstRd ? instr[15:11] : instr[20:16];
	assign regWrite = writesReg && known && (destReg != '0);

endmodule

// ==== mipsPkg.sv ====
package mipsPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0] regIdxT;
	typedef logic [5:0] opcodeT;
	typedef logic [5:0] functT;
	typedef logic [3:0] aluOpT;
	typedef logic [1:0] fwdSelT;

	// Primary opcodes
	parameter opcodeT opRtype = 6'd0;
	parameter opcodeT opJ     = 6'd2;
	parameter opcodeT opBeq   = 6'd4;
	parameter opcodeT opBne   = 6'd5;
	parameter opcodeT opAddi  = 6'd8;
	parameter opcodeT opAddiu = 6'd9;
	parameter opcodeT opSlti  = 6'd10;
	parameter opcodeT opSltiu = 6'd11;
	parameter opcodeT opAndi  = 6'd12;
	parameter opcodeT opOri   = 6'd13;
	parameter opcodeT opXori  = 6'd14;
	parameter opcodeT opLui   = 6'd15;
	parameter opcodeT opLw    = 6'd35;
	parameter opcodeT opSw    = 6'd43;

	// Function field, register-type only
	parameter functT fnAdd  = 6'd32;
	parameter functT fnAddu = 6'd33;
	parameter functT fnSub  = 6'd34;
	parameter functT fnSubu = 6'd35;
	parameter functT fnAnd  = 6'd36;
	parameter functT fnOr   = 6'd37;
	parameter functT fnXor  = 6'd38;
	parameter functT fnNor  = 6'd39;
	parameter functT fnSlt  = 6'd42;
	parameter functT fnSltu = 6'd43;

	parameter aluOpT aluAnd  = 4'd0;
	parameter aluOpT aluOr   = 4'd1;
	parameter aluOpT aluAdd  = 4'd2;
	parameter aluOpT aluNor  = 4'd3;
	parameter aluOpT aluXor  = 4'd4;
	parameter aluOpT aluSub  = 4'd6;
	parameter aluOpT aluSlt  = 4'd7;
	parameter aluOpT aluLui  = 4'd10;
	parameter aluOpT aluSltu = 4'd14;

	parameter fwdSelT fwdNone = 2'd0; // Register file value
	parameter fwdSelT fwdMem  = 2'd1;
	parameter fwdSelT fwdWb   = 2'd2;

	parameter wordT resetPc = 32'h0000_0000;

endpackage
